// File: src/uart_rx_pkg.sv
package uart_rx_pkg;

    localparam int DATA_WIDTH_DEF   = 8;   // data bits per frame
    localparam int CLKS_PER_BIT_DEF = 16;  // clk cycles in one bit period

    // frame FSM states, one per field of the frame
    typedef enum logic [2:0] {
        RX_IDLE   = 3'd0,  // line idle, waiting for a start edge
        RX_START  = 3'd1,  // inside the start bit
        RX_DATA   = 3'd2,  // sampling data bits, LSB first
        RX_PARITY = 3'd3,  // even parity bit
        RX_STOP   = 3'd4   // single stop bit
    } rx_state_t;

    // status that travels with each received word
    typedef struct packed {
        logic parity_err;  // data plus parity had an odd count of ones
        logic frame_err;   // stop bit sampled low
        logic overrun;     // a word was dropped before this one
    } rx_status_t;

endpackage

// File: src/rx_sync.sv
`timescale 1ns/1ps

module rx_sync (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic rx_line,
    output logic start_edge
);

    logic sync_meta;  // first stage, may go metastable
    logic line_prev;  // rx_line one cycle back

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_meta  <= 1'b1;  // idle level
            rx_line    <= 1'b1;
            line_prev  <= 1'b1;  // no edge right after reset
            start_edge <= 1'b0;
        end else begin
            sync_meta  <= rx;
            rx_line    <= sync_meta;
            line_prev  <= rx_line;
            start_edge <= line_prev & ~rx_line;  // high to low on rx_line
        end
    end

endmodule

// File: src/rx_baud.sv
`timescale 1ns/1ps

module rx_baud #(
    parameter int CLKS_PER_BIT = uart_rx_pkg::CLKS_PER_BIT_DEF
) (
    input  logic clk,
    input  logic reset,
    input  logic start_edge,
    input  logic hunting,
    output logic sample_strobe
);

    localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CW-1:0] HALF_LOAD = CW'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CW-1:0] FULL_LOAD = CW'(CLKS_PER_BIT - 1);

    logic [CW-1:0] bit_cnt;  // cycles left to the next sample point

    // the counter free-runs in bit periods and is only realigned
    // while the FSM is hunting for a new start bit
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt <= FULL_LOAD;
        end else if (start_edge && hunting) begin
            bit_cnt <= HALF_LOAD;  // half a bit to the middle of start
        end else if (bit_cnt == '0) begin
            bit_cnt <= FULL_LOAD;  // next bit centre
        end else begin
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    assign sample_strobe = (bit_cnt == '0);

    a_strobe_single: assert property (@(posedge clk) disable iff (reset)
        sample_strobe |=> !sample_strobe);

endmodule

// File: src/rx_state.sv
`timescale 1ns/1ps

module rx_state #(
    parameter int DATA_WIDTH = uart_rx_pkg::DATA_WIDTH_DEF
) (
    input  logic clk,
    input  logic reset,
    input  logic sample_strobe,
    input  logic rx_line,
    output logic hunting,
    output logic shift_en,
    output logic parity_en,
    output logic stop_en
);

    localparam int IW = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;
    localparam logic [IW-1:0] LAST_BIT = IW'(DATA_WIDTH - 1);

    uart_rx_pkg::rx_state_t state;
    logic [IW-1:0]          bit_idx;     // data bit being sampled
    logic                   line_low_q;  // rx_line was low last cycle

    assign hunting = (state == uart_rx_pkg::RX_IDLE);

    // lines up with start_edge, so the baud counter is realigned
    // while the FSM is still in idle
    always_ff @(posedge clk) begin
        if (reset) begin
            line_low_q <= 1'b0;
        end else begin
            line_low_q <= ~rx_line;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= uart_rx_pkg::RX_IDLE;
            bit_idx <= '0;
        end else begin
            case (state)
                uart_rx_pkg::RX_IDLE: begin
                    bit_idx <= '0;
                    if (line_low_q) begin
                        state <= uart_rx_pkg::RX_START;
                    end
                end
                uart_rx_pkg::RX_START: begin
                    if (sample_strobe) begin
                        // high at mid-bit means the low pulse was a glitch
                        state <= rx_line ? uart_rx_pkg::RX_IDLE : uart_rx_pkg::RX_DATA;
                    end
                end
                uart_rx_pkg::RX_DATA: begin
                    if (sample_strobe) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT) begin
                            state <= uart_rx_pkg::RX_PARITY;
                        end
                    end
                end
                uart_rx_pkg::RX_PARITY: begin
                    if (sample_strobe) begin
                        state <= uart_rx_pkg::RX_STOP;
                    end
                end
                uart_rx_pkg::RX_STOP: begin
                    if (sample_strobe) begin
                        state <= uart_rx_pkg::RX_IDLE;
                    end
                end
                default: state <= uart_rx_pkg::RX_IDLE;
            endcase
        end
    end

    // one-cycle qualifiers, rx_line is still mid-bit when they are seen
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_en  <= 1'b0;
            parity_en <= 1'b0;
            stop_en   <= 1'b0;
        end else begin
            shift_en  <= sample_strobe && (state == uart_rx_pkg::RX_DATA);
            parity_en <= sample_strobe && (state == uart_rx_pkg::RX_PARITY);
            stop_en   <= sample_strobe && (state == uart_rx_pkg::RX_STOP);
        end
    end

    a_shift_in_data: assert property (@(posedge clk) disable iff (reset)
        shift_en |-> $past(state) == uart_rx_pkg::RX_DATA);

    a_qual_exclusive: assert property (@(posedge clk) disable iff (reset)
        $onehot0({shift_en, parity_en, stop_en}));

endmodule

// File: src/rx_shift.sv
`timescale 1ns/1ps

module rx_shift #(
    parameter int DATA_WIDTH = uart_rx_pkg::DATA_WIDTH_DEF
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rx_line,
    input  logic                  shift_en,
    input  logic                  parity_en,
    input  logic                  stop_en,
    output logic [DATA_WIDTH-1:0] rx_data,
    output logic                  parity_err,
    output logic                  frame_err,
    output logic                  word_done
);

    logic [DATA_WIDTH-1:0] shift_q;     // received bits, first one ends at bit 0
    logic                  parity_acc;  // xor of data bits so far

    assign rx_data = shift_q;

    always_ff @(posedge clk) begin
        if (shift_en) begin
            shift_q <= {rx_line, shift_q[DATA_WIDTH-1:1]};  // lsb first
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            parity_acc <= 1'b0;
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
            word_done  <= 1'b0;
        end else begin
            word_done <= stop_en;  // results are final one cycle after stop
            if (shift_en) begin
                parity_acc <= parity_acc ^ rx_line;
            end
            if (parity_en) begin
                parity_err <= parity_acc ^ rx_line;  // odd total of ones
            end
            if (stop_en) begin
                frame_err  <= ~rx_line;  // stop must be high
                parity_acc <= 1'b0;      // clean start for next frame
            end
        end
    end

endmodule

// File: src/rx_handoff.sv
`timescale 1ns/1ps

module rx_handoff #(
    parameter int DATA_WIDTH = uart_rx_pkg::DATA_WIDTH_DEF
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  word_done,
    input  logic                  parity_err,
    input  logic                  frame_err,
    input  logic [DATA_WIDTH-1:0] rx_data,
    input  logic                  ack,
    output logic                  req,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  parity_err_out,
    output logic                  frame_err_out,
    output logic                  overrun_out
);

    uart_rx_pkg::rx_status_t status_q;      // flags of the offered word
    logic [DATA_WIDTH-1:0]   data_q;
    logic                    overrun_pend;  // dropped word not yet reported
    logic                    busy;          // handshake still in progress
    logic                    accept;

    assign busy   = req | ack;
    assign accept = word_done & ~busy;  // only once ack has dropped again

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= rx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req          <= 1'b0;
            status_q     <= '0;
            overrun_pend <= 1'b0;
        end else if (accept) begin
            req          <= 1'b1;
            status_q     <= '{parity_err: parity_err,
                              frame_err:  frame_err,
                              overrun:    overrun_pend};
            overrun_pend <= 1'b0;
        end else begin
            if (word_done) begin
                overrun_pend <= 1'b1;  // host still holds the old word
            end
            if (req && ack) begin
                req <= 1'b0;  // phase 3 of the handshake
            end
        end
    end

    assign data_out       = data_q;
    assign parity_err_out = status_q.parity_err;
    assign frame_err_out  = status_q.frame_err;
    assign overrun_out    = status_q.overrun;

    a_data_stable: assert property (@(posedge clk) disable iff (reset)
        req && $past(req) |-> $stable(data_out));

endmodule

// File: src/uart_rx_top.sv
`timescale 1ns/1ps

module uart_rx_top #(
    parameter int DATA_WIDTH   = uart_rx_pkg::DATA_WIDTH_DEF,
    parameter int CLKS_PER_BIT = uart_rx_pkg::CLKS_PER_BIT_DEF
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rx,
    input  logic                  ack,
    output logic                  req,
    output logic                  parity_err_out,
    output logic                  frame_err_out,
    output logic                  overrun_out,
    output logic [DATA_WIDTH-1:0] data_out
);

    logic                  rx_line;        // synchronized serial line
    logic                  start_edge;
    logic                  hunting;        // FSM waits for a start bit
    logic                  sample_strobe;  // mid-bit sample point
    logic                  shift_en;
    logic                  parity_en;
    logic                  stop_en;
    logic [DATA_WIDTH-1:0] rx_data;
    logic                  parity_err;
    logic                  frame_err;
    logic                  word_done;

    rx_sync u_sync (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .rx_line    (rx_line),
        .start_edge (start_edge)
    );

    rx_baud #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_baud (
        .clk           (clk),
        .reset         (reset),
        .start_edge    (start_edge),
        .hunting       (hunting),
        .sample_strobe (sample_strobe)
    );

    rx_state #(.DATA_WIDTH(DATA_WIDTH)) u_state (
        .clk           (clk),
        .reset         (reset),
        .sample_strobe (sample_strobe),
        .rx_line       (rx_line),
        .hunting       (hunting),
        .shift_en      (shift_en),
        .parity_en     (parity_en),
        .stop_en       (stop_en)
    );

    rx_shift #(.DATA_WIDTH(DATA_WIDTH)) u_shift (
        .clk        (clk),
        .reset      (reset),
        .rx_line    (rx_line),
        .shift_en   (shift_en),
        .parity_en  (parity_en),
        .stop_en    (stop_en),
        .rx_data    (rx_data),
        .parity_err (parity_err),
        .frame_err  (frame_err),
        .word_done  (word_done)
    );

    rx_handoff #(.DATA_WIDTH(DATA_WIDTH)) u_handoff (
        .clk            (clk),
        .reset          (reset),
        .word_done      (word_done),
        .parity_err     (parity_err),
        .frame_err      (frame_err),
        .rx_data        (rx_data),
        .ack            (ack),
        .req            (req),
        .data_out       (data_out),
        .parity_err_out (parity_err_out),
        .frame_err_out  (frame_err_out),
        .overrun_out    (overrun_out)
    );

endmodule

// File: include/tb_uart_rx_checks.svh
`ifndef TB_UART_RX_CHECKS_SVH
`define TB_UART_RX_CHECKS_SVH

int data_errors   = 0;  // wrong data_out
int status_errors = 0;  // wrong status flags
int other_errors  = 0;  // timeouts and handshake faults

task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] expected,
                          input logic [DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
        data_errors++;
        $display("FAIL %s: data expected %h actual %h", name, expected, actual);
    end
endtask

// flags print as {parity_err, frame_err, overrun}
task automatic check_status(input string name, input uart_rx_pkg::rx_status_t expected,
                            input uart_rx_pkg::rx_status_t actual);
    if (actual !== expected) begin
        status_errors++;
        $display("FAIL %s: status expected %b actual %b", name, expected, actual);
    end
endtask

task automatic report_fault(input string name, input string what);
    other_errors++;
    $display("ERROR %s: %s", name, what);
endtask

function automatic int total_errors();
    return data_errors + status_errors + other_errors;
endfunction

task automatic print_counts();
    $display("errors: data %0d, status %0d, other %0d", data_errors, status_errors,
             other_errors);
endtask

`endif

// File: test/tb_uart_rx.sv
`timescale 1ns/1ps

module tb_uart_rx;

    localparam int DATA_WIDTH   = uart_rx_pkg::DATA_WIDTH_DEF;
    localparam int CLKS_PER_BIT = uart_rx_pkg::CLKS_PER_BIT_DEF;
    localparam int CLK_PERIOD   = 4;
    localparam int FRAME_CLKS   = (DATA_WIDTH + 5) * CLKS_PER_BIT;  // frame plus 2 idle bits
    localparam int NUM_FRAMES   = 33;  // frames sent over all tests
    localparam int WATCHDOG_NS  = NUM_FRAMES * (DATA_WIDTH + 4) * CLKS_PER_BIT * CLK_PERIOD * 2;
    localparam uart_rx_pkg::rx_status_t NO_FLAGS = '0;

    logic                  clk;
    logic                  reset;
    logic                  rx;
    logic                  ack;
    logic                  req;
    logic                  parity_err_out;
    logic                  frame_err_out;
    logic                  overrun_out;
    logic [DATA_WIDTH-1:0] data_out;
    logic [31:0]           rng_state;

    `include "tb_uart_rx_checks.svh"

    uart_rx_top #(.DATA_WIDTH(DATA_WIDTH), .CLKS_PER_BIT(CLKS_PER_BIT)) u_dut (
        .clk            (clk),
        .reset          (reset),
        .rx             (rx),
        .ack            (ack),
        .req            (req),
        .parity_err_out (parity_err_out),
        .frame_err_out  (frame_err_out),
        .overrun_out    (overrun_out),
        .data_out       (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run timed out after %0d ns", WATCHDOG_NS);
        print_counts();
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] next_data();
        rng_state = xorshift32(rng_state);
        return rng_state[DATA_WIDTH-1:0];
    endfunction

    function automatic uart_rx_pkg::rx_status_t make_status(input logic p, input logic f,
                                                            input logic o);
        uart_rx_pkg::rx_status_t s;
        s.parity_err = p;
        s.frame_err  = f;
        s.overrun    = o;
        return s;
    endfunction

    task automatic drive_bit(input logic level);
        rx = level;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    // even parity, LSB first
    task automatic send_frame(input logic [DATA_WIDTH-1:0] data, input bit bad_parity,
                              input bit bad_stop);
        drive_bit(1'b0);
        for (int i = 0; i < DATA_WIDTH; i++) begin
            drive_bit(data[i]);
        end
        drive_bit((^data) ^ bad_parity);
        drive_bit(~bad_stop);
        drive_bit(1'b1);  // idle gap lets the FSM settle after a low stop bit
        drive_bit(1'b1);
    endtask

    task automatic wait_req(input string name, output bit seen);
        int n;
        n = 0;
        while (!req && n < FRAME_CLKS) begin
            @(negedge clk);
            n++;
        end
        seen = req;
        if (!seen) report_fault(name, "req never rose");
    endtask

    task automatic watch_no_req(input string name, input int cycles);
        bit fired;
        fired = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            if (req && !fired) begin
                fired = 1'b1;
                report_fault(name, "req rose when no word was due");
            end
        end
    endtask

    task automatic host_take(input string name, input logic [DATA_WIDTH-1:0] exp_data,
                             input uart_rx_pkg::rx_status_t exp_status,
                             input int ack_delay, input bit hold_ack);
        bit seen;
        int n;
        wait_req(name, seen);
        if (!seen) return;
        check_data(name, exp_data, data_out);
        check_status(name, exp_status, make_status(parity_err_out, frame_err_out, overrun_out));
        repeat (ack_delay) begin  // slow host, req has to wait
            @(negedge clk);
            if (!req) report_fault(name, "req fell before ack rose");
            check_data(name, exp_data, data_out);
        end
        ack = 1'b1;
        n = 0;
        while (req && n < 8) begin
            @(negedge clk);
            n++;
            check_data(name, exp_data, data_out);
        end
        if (req) report_fault(name, "req stayed high after ack");
        if (!hold_ack) ack = 1'b0;
        @(negedge clk);
    endtask

    task automatic receive_random_words();
        logic [DATA_WIDTH-1:0] d;
        for (int i = 0; i < 20; i++) begin
            d = next_data();
            send_frame(d, 1'b0, 1'b0);
            host_take($sformatf("basic[%0d]", i), d, NO_FLAGS, 0, 1'b0);
        end
    endtask

    task automatic flag_parity_and_stop();
        logic [DATA_WIDTH-1:0] d;
        d = next_data();
        send_frame(d, 1'b1, 1'b0);
        host_take("parity_error", d, make_status(1'b1, 1'b0, 1'b0), 0, 1'b0);
        d = next_data();
        send_frame(d, 1'b0, 1'b1);
        host_take("frame_error", d, make_status(1'b0, 1'b1, 1'b0), 0, 1'b0);
    endtask

    task automatic reject_false_start();
        logic [DATA_WIDTH-1:0] d;
        rx = 1'b0;  // glitch well short of half a bit
        repeat (CLKS_PER_BIT / 4) @(negedge clk);
        rx = 1'b1;
        watch_no_req("false_start", FRAME_CLKS);
        d = next_data();
        send_frame(d, 1'b0, 1'b0);
        host_take("false_start next", d, NO_FLAGS, 0, 1'b0);
    endtask

    task automatic drop_while_pending();
        logic [DATA_WIDTH-1:0] first;
        logic [DATA_WIDTH-1:0] d;
        bit                    seen;
        first = next_data();
        send_frame(first, 1'b0, 1'b0);
        wait_req("overrun", seen);
        if (!seen) return;
        send_frame(next_data(), 1'b0, 1'b0);  // both dropped, req left pending
        send_frame(next_data(), 1'b0, 1'b0);
        host_take("overrun pending", first, NO_FLAGS, 0, 1'b0);
        d = next_data();
        send_frame(d, 1'b0, 1'b0);
        host_take("overrun flagged", d, make_status(1'b0, 1'b0, 1'b1), 0, 1'b0);
        d = next_data();
        send_frame(d, 1'b0, 1'b0);
        host_take("overrun cleared", d, NO_FLAGS, 0, 1'b0);
    endtask

    task automatic follow_handshake();
        logic [DATA_WIDTH-1:0] d;
        d = next_data();
        send_frame(d, 1'b0, 1'b0);
        host_take("handshake slow ack", d, NO_FLAGS, 2 * CLKS_PER_BIT, 1'b0);
        d = next_data();
        send_frame(d, 1'b0, 1'b0);
        host_take("handshake ack held", d, NO_FLAGS, 0, 1'b1);
        fork  // word arrives while ack is still high
            send_frame(next_data(), 1'b0, 1'b0);
            watch_no_req("handshake ack held", FRAME_CLKS);
        join
        ack = 1'b0;
        d = next_data();
        send_frame(d, 1'b0, 1'b0);
        host_take("handshake after drop", d, make_status(1'b0, 1'b0, 1'b1), 0, 1'b0);
        d = next_data();
        send_frame(d, 1'b0, 1'b0);
        host_take("handshake clear", d, NO_FLAGS, 0, 1'b0);
    endtask

    initial begin
        rng_state = 32'd19;
        reset     = 1'b1;
        rx        = 1'b1;  // line idles high
        ack       = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk);
        receive_random_words();
        flag_parity_and_stop();
        reject_false_start();
        drop_while_pending();
        follow_handshake();
        print_counts();
        if (total_errors() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: uart_rx.f
+incdir+include
src/uart_rx_pkg.sv
src/rx_sync.sv
src/rx_baud.sv
src/rx_state.sv
src/rx_shift.sv
src/rx_handoff.sv
src/uart_rx_top.sv
test/tb_uart_rx.sv

// File: Makefile
SRCS := $(wildcard src/*.sv test/*.sv include/*.svh)

obj_dir/Vtb_uart_rx: uart_rx.f $(SRCS)
	verilator --binary --timing --assert -f uart_rx.f --top-module tb_uart_rx -o Vtb_uart_rx

run: obj_dir/Vtb_uart_rx
	@out="$$(obj_dir/Vtb_uart_rx)"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

.PHONY: run clean
